//--- verilog/gpuDrawPkg.sv
// Shared definitions for the 2D pixel-writing engine
// Frame geometry, field widths, queue depth, fill pacing and the fill FSM states

package gpuDrawPkg;

    // ************************************************************
    // Frame geometry
    // ************************************************************
    localparam int hDisp = 1024;          // Pixels per line
    localparam int vDisp = 600;           // Lines per frame

    // ************************************************************
    // Field widths
    // ************************************************************
    localparam int coordWidth = 16;       // X and y coordinates
    localparam int addrWidth  = 32;       // Linear pixel address
    localparam int colorWidth = 24;       // RGB888 pixel
    localparam int lenWidth   = 24;       // Run length of one fill

    // ************************************************************
    // Queue depth and pacing
    // ************************************************************
    localparam int plotDepth = 4;         // Entries in the plot queue
    localparam int fillPace  = 2;         // Cycles between two fill strobes

    // States of the span fill unit
    typedef enum logic [2:0] {
        Idle,                             // Waiting for a start pulse
        Load,                             // Start address is computed
        Write,                            // One pixel strobe
        Gap,                              // Spacing between strobes
        Finish                            // Done pulse
    } fillState;

endpackage

//--- verilog/memWriteIf.sv
// Write port of one pixel producer
// Strobe, address and colour toward the arbiter, hold level back

interface memWriteIf;

    logic                             we;      // One pixel write this cycle
    logic [gpuDrawPkg::addrWidth-1:0] addr;    // Valid while we is high
    logic [gpuDrawPkg::colorWidth-1:0] data;   // Valid while we is high
    logic                             hold;    // Source keeps we low and its entry

    modport source (
        output we,
        output addr,
        output data,
        input  hold
    );

    modport sink (
        input  we,
        input  addr,
        input  data,
        output hold
    );

endinterface

//--- verilog/spanFillUnit.sv
// Span fill unit
// Writes one colour to a horizontal run of pixels, one strobe every fillPace cycles

module spanFillUnit (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start,
    input  logic [gpuDrawPkg::coordWidth-1:0] startX,
    input  logic [gpuDrawPkg::coordWidth-1:0] startY,
    input  logic [gpuDrawPkg::colorWidth-1:0] fillColor,
    input  logic [gpuDrawPkg::lenWidth-1:0]   fillLen,
    output logic                              busy,
    output logic                              done,
    memWriteIf.source                         wr
);

    gpuDrawPkg::fillState                    state;
    logic [gpuDrawPkg::coordWidth-1:0]       xReg;
    logic [gpuDrawPkg::coordWidth-1:0]       yReg;
    logic [gpuDrawPkg::colorWidth-1:0]       colorReg;
    logic [gpuDrawPkg::lenWidth-1:0]         lenReg;
    logic [gpuDrawPkg::addrWidth-1:0]        addrReg;
    logic [gpuDrawPkg::lenWidth-1:0]         pixCnt;   // Strobes made so far
    logic [$clog2(gpuDrawPkg::fillPace)-1:0] paceCnt;  // Cycles spent in Gap

    // ************************************************************
    // Control FSM
    // ************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= gpuDrawPkg::Idle;
            pixCnt  <= '0;
            paceCnt <= '0;
        end else begin
            case (state)
                gpuDrawPkg::Idle: begin
                    if (start) begin
                        state  <= gpuDrawPkg::Load;
                        pixCnt <= '0;
                    end
                end
                gpuDrawPkg::Load: begin
                    paceCnt <= '0;
                    state   <= (lenReg == '0) ? gpuDrawPkg::Finish : gpuDrawPkg::Write;
                end
                gpuDrawPkg::Write: begin
                    pixCnt <= pixCnt + 1'b1;
                    if (pixCnt == lenReg - 1'b1) begin
                        state <= gpuDrawPkg::Finish;   // Last pixel of the run
                    end else begin
                        state <= gpuDrawPkg::Gap;
                    end
                end
                gpuDrawPkg::Gap: begin
                    if (paceCnt == gpuDrawPkg::fillPace - 2) begin
                        paceCnt <= '0;
                        state   <= gpuDrawPkg::Write;
                    end else begin
                        paceCnt <= paceCnt + 1'b1;
                    end
                end
                gpuDrawPkg::Finish: begin
                    state <= gpuDrawPkg::Idle;
                end
                default: begin
                    state <= gpuDrawPkg::Idle;
                end
            endcase
        end
    end

    // ************************************************************
    // Command and address registers
    // ************************************************************
    always_ff @(posedge clk) begin
        if (state == gpuDrawPkg::Idle && start) begin
            xReg     <= startX;
            yReg     <= startY;
            colorReg <= fillColor;
            lenReg   <= fillLen;
        end
        if (state == gpuDrawPkg::Load) begin
            addrReg <= xReg + yReg * gpuDrawPkg::hDisp;       // Start of the run
        end else if (state == gpuDrawPkg::Write) begin
            addrReg <= addrReg + 1'b1;
        end
    end

    assign busy    = (state == gpuDrawPkg::Load) || (state == gpuDrawPkg::Write) ||
                     (state == gpuDrawPkg::Gap);
    assign done    = (state == gpuDrawPkg::Finish);
    assign wr.we   = (state == gpuDrawPkg::Write);
    assign wr.addr = addrReg;
    assign wr.data = colorReg;

endmodule

//--- verilog/pixelPlotQueue.sv
// Pixel plot queue
// Buffers single-pixel writes and drains them whenever the arbiter does not hold it

module pixelPlotQueue (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              plotValid,
    input  logic [gpuDrawPkg::coordWidth-1:0] plotX,
    input  logic [gpuDrawPkg::coordWidth-1:0] plotY,
    input  logic [gpuDrawPkg::colorWidth-1:0] plotColor,
    output logic                              full,
    memWriteIf.source                         wr
);

    logic [gpuDrawPkg::addrWidth-1:0]           addrMem  [gpuDrawPkg::plotDepth];
    logic [gpuDrawPkg::colorWidth-1:0]          colorMem [gpuDrawPkg::plotDepth];
    logic [$clog2(gpuDrawPkg::plotDepth)-1:0]   wrPtr;
    logic [$clog2(gpuDrawPkg::plotDepth)-1:0]   rdPtr;
    logic [$clog2(gpuDrawPkg::plotDepth+1)-1:0] count;
    logic                                       empty;
    logic                                       push;
    logic                                       pop;

    assign full  = (count == gpuDrawPkg::plotDepth);
    assign empty = (count == '0);
    assign push  = plotValid && !full;       // A strobe while full is dropped
    assign pop   = !empty && !wr.hold;

    // ************************************************************
    // Pointers and fill level
    // ************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == gpuDrawPkg::plotDepth - 1) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == gpuDrawPkg::plotDepth - 1) ? '0 : rdPtr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Address is formed once on push
    always_ff @(posedge clk) begin
        if (push) begin
            addrMem[wrPtr]  <= plotX + plotY * gpuDrawPkg::hDisp;
            colorMem[wrPtr] <= plotColor;
        end
    end

    assign wr.we   = pop;                    // Head leaves in the cycle it is shown
    assign wr.addr = addrMem[rdPtr];
    assign wr.data = colorMem[rdPtr];

endmodule

//--- verilog/writeArbiter.sv
// Write arbiter
// Fill writes win, plot writes take the free cycles, result is registered

module writeArbiter (
    input  logic                              clk,
    input  logic                              rst_n,
    memWriteIf.sink                           fillWr,
    memWriteIf.sink                           plotWr,
    output logic                              memWe,
    output logic [gpuDrawPkg::addrWidth-1:0]  memAddr,
    output logic [gpuDrawPkg::colorWidth-1:0] memData
);

    assign fillWr.hold = 1'b0;               // Fill always wins
    assign plotWr.hold = fillWr.we;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            memWe <= 1'b0;
        end else begin
            memWe <= fillWr.we || plotWr.we;
        end
    end

    // ************************************************************
    // Memory write payload
    // ************************************************************
    always_ff @(posedge clk) begin
        if (fillWr.we) begin
            memAddr <= fillWr.addr;
            memData <= fillWr.data;
        end else begin
            memAddr <= plotWr.addr;
            memData <= plotWr.data;
        end
    end

endmodule

//--- verilog/gpuDrawTop.sv
// Pixel-writing engine top level
// Span fill unit and plot queue merged into one memory write stream

module gpuDrawTop (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start,
    input  logic [gpuDrawPkg::coordWidth-1:0] startX,
    input  logic [gpuDrawPkg::coordWidth-1:0] startY,
    input  logic [gpuDrawPkg::colorWidth-1:0] fillColor,
    input  logic [gpuDrawPkg::lenWidth-1:0]   fillLen,
    input  logic                              plotValid,
    input  logic [gpuDrawPkg::coordWidth-1:0] plotX,
    input  logic [gpuDrawPkg::coordWidth-1:0] plotY,
    input  logic [gpuDrawPkg::colorWidth-1:0] plotColor,
    output logic                              fillBusy,
    output logic                              fillDone,
    output logic                              plotFull,
    output logic                              memWe,
    output logic [gpuDrawPkg::addrWidth-1:0]  memAddr,
    output logic [gpuDrawPkg::colorWidth-1:0] memData
);

    memWriteIf fillWr ();                    // Fill unit to arbiter
    memWriteIf plotWr ();                    // Plot queue to arbiter

    spanFillUnit fillUnit_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .startX    (startX),
        .startY    (startY),
        .fillColor (fillColor),
        .fillLen   (fillLen),
        .busy      (fillBusy),
        .done      (fillDone),
        .wr        (fillWr.source)
    );

    pixelPlotQueue plotQueue_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .plotValid (plotValid),
        .plotX     (plotX),
        .plotY     (plotY),
        .plotColor (plotColor),
        .full      (plotFull),
        .wr        (plotWr.source)
    );

    writeArbiter arbiter_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .fillWr  (fillWr.sink),
        .plotWr  (plotWr.sink),
        .memWe   (memWe),
        .memAddr (memAddr),
        .memData (memData)
    );

endmodule

//--- dv/gpuDrawTop_props.sv
// Protocol properties of the pixel-writing engine
// Done pulse width, arbitration and hold rules on the internal write ports

module gpuDrawTopProps (
    input logic clk,
    input logic rst_n,
    input logic fillDone,
    input logic fillWe,
    input logic plotWe,
    input logic plotHold
);

    doneOneCycle: assert property (@(posedge clk) disable iff (!rst_n)
        fillDone |=> !fillDone)
        else $error("fillDone stayed high for more than one cycle");

    singleWinner: assert property (@(posedge clk) disable iff (!rst_n)
        !(fillWe && plotWe))
        else $error("Fill and plot strobes met in one cycle");

    holdRespected: assert property (@(posedge clk) disable iff (!rst_n)
        plotHold |-> !plotWe)
        else $error("Plot strobe while hold was high");

endmodule

bind gpuDrawTop gpuDrawTopProps props_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .fillDone (fillDone),
    .fillWe   (fillWr.we),
    .plotWe   (plotWr.we),
    .plotHold (plotWr.hold)
);

//--- dv/gpuDrawTb.sv
// Testbench for the pixel-writing engine
// Random fills and plots checked against a queue model of the memory write stream

module gpuDrawTb;

    localparam int numFills  = 20;
    localparam int maxPlots  = 150;
    localparam int halfAddr  = (gpuDrawPkg::vDisp / 2) * gpuDrawPkg::hDisp;

    logic                              clk;
    logic                              rst_n;
    logic                              start;
    logic [gpuDrawPkg::coordWidth-1:0] startX, startY, plotX, plotY;
    logic [gpuDrawPkg::colorWidth-1:0] fillColor, plotColor, memData;
    logic [gpuDrawPkg::lenWidth-1:0]   fillLen;
    logic                              plotValid, fillBusy, fillDone, plotFull, memWe;
    logic [gpuDrawPkg::addrWidth-1:0]  memAddr;

    logic [31:0] seed = 32'h3811d16a;
    logic [31:0] fillAddrQ[$], fillColorQ[$], plotAddrQ[$], plotColorQ[$];
    int          errCount[3];             // Fill, plot and timing errors
    int          fillLens[numFills];
    int          cycle, acceptCycle, lastFillCycle, curLen, totalLen, limitCycles;
    int          plotMode, plotsIssued;   // 0 off, 1 burst, 2 random
    bit          fillInRun, sawFull, limitSet, expFull;

    gpuDrawTop dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed ^ (seed >> 16);
    endfunction

    task automatic compareValue(input string test, input logic [31:0] expected,
                                input logic [31:0] actual, input int kind);
        assert (expected == actual) else begin
            $display("[FAIL] %s: expected %h, actual %h", test, expected, actual);
            errCount[kind]++;
        end
    endtask

    // ************************************************************
    // Write stream monitor
    // ************************************************************
    task automatic scoreWrite();
        if (memAddr < halfAddr) begin                // Fills live in the upper half
            assert (fillAddrQ.size() > 0) else begin
                $display("Fill write to %h arrived with no fill pixel pending", memAddr);
                errCount[0]++;
            end
            if (fillAddrQ.size() > 0) begin
                compareValue("fill address", fillAddrQ.pop_front(), memAddr, 0);
                compareValue("fill colour", fillColorQ.pop_front(), memData, 0);
            end
            if (fillInRun)
                compareValue("fill spacing", gpuDrawPkg::fillPace, cycle - lastFillCycle, 2);
            else
                compareValue("first fill write", 3, cycle - acceptCycle, 2);
            fillInRun     = 1'b1;
            lastFillCycle = cycle;
        end else begin
            assert (plotAddrQ.size() > 0) else begin
                $display("Plot write to %h arrived with no plot pending", memAddr);
                errCount[1]++;
            end
            if (plotAddrQ.size() > 0) begin
                compareValue("plot address", plotAddrQ.pop_front(), memAddr, 1);
                compareValue("plot colour", plotColorQ.pop_front(), memData, 1);
            end
        end
    endtask

    task automatic verifyDone();
        compareValue("busy at done", 0, fillBusy, 2);
        assert (fillAddrQ.size() == 0) else begin
            $display("Fill done came with %0d pixels unwritten", fillAddrQ.size());
            errCount[0]++;
        end
        // The last registered write shares its cycle with the done pulse
        if (curLen == 0)
            compareValue("empty fill done", 2, cycle - acceptCycle, 2);
        else
            compareValue("fill done delay", 0, cycle - lastFillCycle, 2);
        fillInRun = 1'b0;
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            cycle++;
            if (memWe)
                scoreWrite();
            expFull = (plotAddrQ.size() >= gpuDrawPkg::plotDepth);   // Queue level now
            compareValue("plot full", expFull, plotFull, 1);
            if (plotValid && !expFull) begin         // Accepted push, in order
                plotAddrQ.push_back(plotX + plotY * gpuDrawPkg::hDisp);
                plotColorQ.push_back(plotColor);
            end
            if (plotFull && plotMode == 1)
                sawFull = 1'b1;
            if (fillDone)
                verifyDone();
        end
    end

    // ************************************************************
    // Stimulus
    // ************************************************************
    initial begin
        logic fullSeen;
        logic v;
        forever begin
            @(negedge clk);
            fullSeen = plotFull;
            @(posedge clk);
            v = (plotMode == 1) ? !fullSeen :
                (plotMode == 2 && plotsIssued < maxPlots && !fullSeen && nextRand() % 3 == 0);
            plotValid <= v;
            if (v) begin
                plotX     <= nextRand() % gpuDrawPkg::hDisp;
                plotY     <= gpuDrawPkg::vDisp / 2 + nextRand() % (gpuDrawPkg::vDisp / 2);
                plotColor <= nextRand();
                plotsIssued++;
            end
        end
    end

    task automatic issueFill(input int x, input int y, input int len);
        logic [31:0] color;
        color = nextRand() & 32'hffffff;
        @(posedge clk);
        for (int i = 0; i < len; i++) begin
            fillAddrQ.push_back(x + y * gpuDrawPkg::hDisp + i);
            fillColorQ.push_back(color);
        end
        curLen      = len;
        acceptCycle = cycle + 1;                     // Cycle that carries the start
        start     <= 1'b1;
        startX    <= x;
        startY    <= y;
        fillColor <= color;
        fillLen   <= len;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        compareValue("busy after start", 1, fillBusy, 2);
        @(negedge clk);
        if (fillBusy && len > 1) begin               // This start must be ignored
            @(posedge clk);
            start     <= 1'b1;
            startX    <= nextRand() % gpuDrawPkg::hDisp;
            fillColor <= nextRand();
            fillLen   <= 24'd7;
            @(posedge clk);
            start <= 1'b0;
            @(negedge clk);
        end
        while (!fillDone)
            @(negedge clk);
    endtask

    task automatic drainPlots();
        while (plotAddrQ.size() != 0)
            @(negedge clk);
        repeat (4) @(negedge clk);
    endtask

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        startX    = '0;
        startY    = '0;
        fillColor = '0;
        fillLen   = '0;
        plotValid = 1'b0;
        plotX     = '0;
        plotY     = '0;
        plotColor = '0;
        totalLen = 40;
        for (int i = 0; i < numFills; i++) begin
            fillLens[i] = nextRand() % 41;
            totalLen += fillLens[i];
        end
        limitCycles = totalLen * 4 + maxPlots * 8 + 2000;
        limitSet    = 1'b1;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        compareValue("reset fillBusy", 0, fillBusy, 2);
        compareValue("reset fillDone", 0, fillDone, 2);
        compareValue("reset plotFull", 0, plotFull, 2);
        compareValue("reset memWe", 0, memWe, 2);

        plotMode = 1;                                 // Plots pile up behind a long fill
        issueFill(nextRand() % (gpuDrawPkg::hDisp - 41), nextRand() % 300, 40);
        plotMode = 0;
        drainPlots();
        assert (sawFull) else begin
            $display("Plot queue never reported full during the burst");
            errCount[1]++;
        end

        plotMode = 2;
        for (int i = 0; i < numFills; i++)
            issueFill(nextRand() % (gpuDrawPkg::hDisp - 41), nextRand() % 300, fillLens[i]);
        plotMode = 0;
        drainPlots();
        assert (fillAddrQ.size() == 0 && plotAddrQ.size() == 0) else begin
            $display("Writes never reached memory: %0d fill, %0d plot",
                     fillAddrQ.size(), plotAddrQ.size());
            errCount[2]++;
        end

        $display("Errors: fill %0d, plot %0d, timing %0d", errCount[0], errCount[1], errCount[2]);
        if (errCount[0] + errCount[1] + errCount[2] == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial begin
        wait (limitSet);
        repeat (limitCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles", limitCycles);
        $display("Errors: fill %0d, plot %0d, timing %0d", errCount[0], errCount[1], errCount[2]);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- build.f
verilog/gpuDrawPkg.sv
verilog/memWriteIf.sv
verilog/spanFillUnit.sv
verilog/pixelPlotQueue.sv
verilog/writeArbiter.sv
verilog/gpuDrawTop.sv
dv/gpuDrawTop_props.sv
dv/gpuDrawTb.sv

//--- Bender.yml
package:
  name: gpu_draw

sources:
  - verilog/gpuDrawPkg.sv
  - verilog/memWriteIf.sv
  - verilog/spanFillUnit.sv
  - verilog/pixelPlotQueue.sv
  - verilog/writeArbiter.sv
  - verilog/gpuDrawTop.sv
  - target: test
    files:
      - dv/gpuDrawTop_props.sv
      - dv/gpuDrawTb.sv
